//--- rtl/board_pkg.sv
package board_pkg;

    // ----------------------------------------
    // VGA 640x480 raster

    localparam int w_x     = 10;
    localparam int w_y     = 10;
    localparam int w_color = 4;

    localparam int h_visible = 640;
    localparam int h_front   = 16;
    localparam int h_sync    = 96;
    localparam int h_back    = 48;
    localparam int h_total   = h_visible + h_front + h_sync + h_back;  // 800

    localparam int v_visible = 480;
    localparam int v_front   = 10;
    localparam int v_sync    = 2;
    localparam int v_back    = 33;
    localparam int v_total   = v_visible + v_front + v_sync + v_back;  // 525

    // ----------------------------------------
    // TM1638 module

    localparam int tm_digits = 8;
    localparam int tm_leds   = 8;
    localparam int tm_keys   = 8;
    localparam int w_seg     = 8;  // Segment a in bit 0 and the dot in bit 7

    localparam logic [7:0] cmd_write_auto = 8'h40;  // Write with auto increment
    localparam logic [7:0] cmd_addr_base  = 8'hC0;
    localparam logic [7:0] cmd_display_on = 8'h8F;  // Full brightness
    localparam logic [7:0] cmd_read_keys  = 8'h42;

    function automatic logic [w_seg-1:0] hex_font(input logic [3:0] nibble);
        case (nibble)
            4'h0: hex_font = 8'h3F;
            4'h1: hex_font = 8'h06;
            4'h2: hex_font = 8'h5B;
            4'h3: hex_font = 8'h4F;
            4'h4: hex_font = 8'h66;
            4'h5: hex_font = 8'h6D;
            4'h6: hex_font = 8'h7D;
            4'h7: hex_font = 8'h07;
            4'h8: hex_font = 8'h7F;
            4'h9: hex_font = 8'h6F;
            4'hA: hex_font = 8'h77;
            4'hB: hex_font = 8'h7C;  // Lower case b
            4'hC: hex_font = 8'h39;
            4'hD: hex_font = 8'h5E;  // Lower case d
            4'hE: hex_font = 8'h79;
            default: hex_font = 8'h71;
        endcase
    endfunction

endpackage

//--- rtl/tm1638_if.sv
interface tm1638_if import board_pkg::*; ();

    logic [w_seg-1:0]     seg;    // Segment byte of the selected digit
    logic [tm_digits-1:0] digit;  // One-hot digit select
    logic [tm_leds-1:0]   led;
    logic [tm_keys-1:0]   keys;

    modport lab (
        output seg,
        output digit,
        output led,
        input  keys
    );

    modport ctrl (
        input  seg,
        input  digit,
        input  led,
        output keys
    );

endinterface

//--- rtl/vga_if.sv
interface vga_if import board_pkg::*; ();

    logic [w_x-1:0] x;
    logic [w_y-1:0] y;
    logic           display_on;
    logic           hsync;       // Active low
    logic           vsync;       // Active low

    modport source (
        output x,
        output y,
        output display_on,
        output hsync,
        output vsync
    );

    modport sink (
        input x,
        input y,
        input display_on
    );

endinterface

//--- rtl/slow_tick_gen.sv
module slow_tick_gen #(
    parameter int clk_mhz     = 50,
    parameter int slow_clk_hz = 1
) (
    input  logic clk,
    input  logic reset,
    output logic slow_tick
);

    localparam int period = clk_mhz * 1_000_000 / slow_clk_hz;
    localparam int w_cnt  = period > 1 ? $clog2(period) : 1;

    logic [w_cnt-1:0] cnt;

    assign slow_tick = (cnt == '0);  // One cycle out of every period

    always_ff @(posedge clk) begin
        if (reset || slow_tick) begin
            cnt <= w_cnt'(period - 1);
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

//--- rtl/vga_timing.sv
module vga_timing import board_pkg::*; #(
    parameter int clk_mhz   = 50,
    parameter int pixel_mhz = 25
) (
    input  logic   clk,
    input  logic   reset,
    vga_if.source  vga
);

    localparam int ratio = clk_mhz / pixel_mhz;
    localparam int w_div = ratio > 1 ? $clog2(ratio) : 1;

    localparam logic [w_x-1:0] h_last   = w_x'(h_total - 1);
    localparam logic [w_y-1:0] v_last   = w_y'(v_total - 1);
    localparam logic [w_x-1:0] hs_start = w_x'(h_visible + h_front);
    localparam logic [w_x-1:0] hs_end   = w_x'(h_visible + h_front + h_sync);
    localparam logic [w_y-1:0] vs_start = w_y'(v_visible + v_front);
    localparam logic [w_y-1:0] vs_end   = w_y'(v_visible + v_front + v_sync);

    logic [w_div-1:0] div_cnt;
    logic             pixel_en;
    logic [w_x-1:0]   h_cnt;
    logic [w_y-1:0]   v_cnt;

    // ----------------------------------------
    // Pixel enable divider

    assign pixel_en = (div_cnt == w_div'(ratio - 1));

    always_ff @(posedge clk) begin
        if (reset || pixel_en) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // Raster counters

    always_ff @(posedge clk) begin
        if (reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (pixel_en) begin
            if (h_cnt == h_last) begin
                h_cnt <= '0;
                if (v_cnt == v_last) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;  // Next line
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Registered outputs one cycle behind the counters

    always_ff @(posedge clk) begin
        if (reset) begin
            vga.display_on <= 1'b0;
            vga.hsync      <= 1'b1;
            vga.vsync      <= 1'b1;
        end else begin
            vga.display_on <= (h_cnt < w_x'(h_visible)) && (v_cnt < w_y'(v_visible));
            vga.hsync      <= !((h_cnt >= hs_start) && (h_cnt < hs_end));
            vga.vsync      <= !((v_cnt >= vs_start) && (v_cnt < vs_end));
        end
    end

    always_ff @(posedge clk) begin
        vga.x <= h_cnt;
        vga.y <= v_cnt;
    end

endmodule

//--- rtl/tm1638_board_controller.sv
module tm1638_board_controller import board_pkg::*; #(
    parameter int clk_mhz    = 50,
    parameter int tm_clk_div = 8
) (
    input  logic   clk,
    input  logic   reset,
    tm1638_if.ctrl tm,
    output logic   sio_clk,
    output logic   sio_stb,
    output logic   sio_data_out,
    output logic   sio_data_oe,
    input  logic   sio_data_in
);

    localparam int gap_len  = 2 * tm_clk_div;
    localparam int wait_len = clk_mhz;  // About 1 us before the first key byte
    localparam int cnt_max  = gap_len > wait_len ? gap_len : wait_len;
    localparam int w_cnt    = $clog2(cnt_max);
    localparam int w_byte   = $clog2(2 * tm_digits + 1);
    localparam int w_addr   = $clog2(2 * tm_digits);
    localparam int w_pair   = $clog2(tm_keys / 2);

    localparam logic [1:0] st_gap  = 2'd0;  // Strobe high between frames
    localparam logic [1:0] st_low  = 2'd1;
    localparam logic [1:0] st_high = 2'd2;
    localparam logic [1:0] st_wait = 2'd3;  // Turnaround after the read command

    logic [1:0]         state;
    logic [w_cnt-1:0]   cnt;
    logic [2:0]         bit_idx;
    logic [w_byte-1:0]  byte_idx;
    logic [w_byte-1:0]  load_idx;
    logic [w_byte-1:0]  last_byte;
    logic [1:0]         frame;
    logic [7:0]         tx_shift;
    logic [7:0]         tx_byte;
    logic [7:0]         rx_shift;
    logic [w_addr-1:0]  data_addr;
    logic [w_pair-1:0]  key_pair;
    logic [tm_keys-1:0] key_acc;
    logic [tm_keys-1:0] key_next;
    logic               reading;
    logic               half_done;
    logic               byte_done;
    logic [w_seg-1:0]   digit_buf [tm_digits];

    // ----------------------------------------
    // Digit buffer filled one digit per cycle

    always_ff @(posedge clk) begin
        for (int i = 0; i < tm_digits; i++) begin
            if (tm.digit[i]) begin
                digit_buf[i] <= tm.seg;
            end
        end
    end

    // ----------------------------------------
    // Byte selection

    assign load_idx  = (state == st_gap) ? '0 : byte_idx + 1'b1;
    assign data_addr = w_addr'(load_idx - 1'b1);
    assign reading   = (frame == 2'd3) && (byte_idx != '0);
    assign half_done = (cnt == w_cnt'(tm_clk_div - 1));
    assign byte_done = (state == st_high) && half_done && (bit_idx == 3'd7);
    assign key_pair  = w_pair'(byte_idx - 1'b1);

    always_comb begin
        case (frame)
            2'd0: begin
                tx_byte   = cmd_write_auto;
                last_byte = '0;
            end
            2'd1: begin
                last_byte = w_byte'(2 * tm_digits);  // Address byte plus 16 data bytes
                if (load_idx == '0) begin
                    tx_byte = cmd_addr_base;
                end else if (data_addr[0]) begin
                    tx_byte = {7'b0, tm.led[data_addr[w_addr-1:1]]};
                end else begin
                    tx_byte = digit_buf[data_addr[w_addr-1:1]];
                end
            end
            2'd2: begin
                tx_byte   = cmd_display_on;
                last_byte = '0;
            end
            default: begin
                tx_byte   = (load_idx == '0) ? cmd_read_keys : 8'hFF;
                last_byte = w_byte'(tm_keys / 2);
            end
        endcase
    end

    // Two keys per read byte in bits 0 and 4
    always_comb begin
        key_next                    = key_acc;
        key_next[{key_pair, 1'b0}] = rx_shift[0];
        key_next[{key_pair, 1'b1}] = rx_shift[4];
    end

    // ----------------------------------------
    // Frame and bit sequencer

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_gap;
            cnt      <= '0;
            bit_idx  <= '0;
            byte_idx <= '0;
            frame    <= '0;
            tx_shift <= '1;
            tm.keys  <= '0;
        end else begin
            cnt <= cnt + 1'b1;
            case (state)
                st_gap: if (cnt == w_cnt'(gap_len - 1)) begin
                    cnt      <= '0;
                    tx_shift <= tx_byte;
                    state    <= st_low;
                end
                st_low: if (half_done) begin
                    cnt   <= '0;
                    state <= st_high;  // Rising sio_clk
                end
                st_high: if (half_done) begin
                    cnt <= '0;
                    if (bit_idx != 3'd7) begin
                        bit_idx  <= bit_idx + 1'b1;
                        tx_shift <= {1'b1, tx_shift[7:1]};  // LSB first
                        state    <= st_low;
                    end else if (byte_idx == last_byte) begin
                        bit_idx  <= '0;
                        byte_idx <= '0;
                        frame    <= frame + 1'b1;
                        tx_shift <= '1;
                        state    <= st_gap;
                    end else if (frame == 2'd3 && byte_idx == '0) begin
                        bit_idx  <= '0;
                        tx_shift <= '1;
                        state    <= st_wait;
                    end else begin
                        bit_idx  <= '0;
                        byte_idx <= byte_idx + 1'b1;
                        tx_shift <= tx_byte;
                        state    <= st_low;
                    end
                end
                default: if (cnt == w_cnt'(wait_len - 1)) begin
                    cnt      <= '0;
                    byte_idx <= byte_idx + 1'b1;
                    tx_shift <= tx_byte;
                    state    <= st_low;
                end
            endcase

            if (byte_done && reading && byte_idx == last_byte) begin
                tm.keys <= key_next;  // All four key bytes in
            end
        end
    end

    // ----------------------------------------
    // Key read path

    always_ff @(posedge clk) begin
        if (state == st_low && half_done && reading) begin
            rx_shift <= {sio_data_in, rx_shift[7:1]};
        end
        if (byte_done && reading) begin
            key_acc <= key_next;
        end
    end

    assign sio_clk      = (state != st_low);
    assign sio_stb      = (state == st_gap);
    assign sio_data_out = tx_shift[0];
    assign sio_data_oe  = !reading;  // Released while the module drives keys

endmodule

//--- rtl/lab_top.sv
module lab_top import board_pkg::*; #(
    parameter int w_key = 12,
    parameter int w_sw  = 3,
    parameter int w_led = 12
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               slow_tick,
    input  logic [w_key-1:0]   key,
    input  logic [w_sw-1:0]    sw,
    output logic [w_led-1:0]   led,
    tm1638_if.lab              tm,
    vga_if.sink                vga,
    output logic [w_color-1:0] red,
    output logic [w_color-1:0] green,
    output logic [w_color-1:0] blue
);

    localparam int w_idx = $clog2(tm_digits);

    logic [31:0]      counter;
    logic [w_idx-1:0] digit_idx;

    // ----------------------------------------
    // Counter

    always_ff @(posedge clk) begin
        if (reset || key[0]) begin
            counter <= '0;
        end else if (slow_tick && sw[0]) begin
            counter <= counter + 1'b1;
        end
    end

    assign led    = counter[w_led-1:0] ^ w_led'(key);
    assign tm.led = led[w_led-1 -: tm_leds];  // Upper LED bits belong to the TM1638

    // ----------------------------------------
    // Hex digits with one digit per cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            digit_idx <= '0;
        end else begin
            digit_idx <= digit_idx + 1'b1;
        end
    end

    assign tm.seg   = hex_font(counter[{digit_idx, 2'b00} +: 4]);
    assign tm.digit = tm_digits'(1) << digit_idx;

    // ----------------------------------------
    // Pixel colors

    always_ff @(posedge clk) begin
        if (reset || !vga.display_on) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else begin
            red   <= vga.x[7 -: w_color];    // Vertical stripes
            green <= vga.y[7 -: w_color];    // Horizontal stripes
            blue  <= counter[w_color-1:0];
        end
    end

endmodule

//--- rtl/board_top.sv
module board_top import board_pkg::*; #(
    parameter int clk_mhz     = 50,
    parameter int pixel_mhz   = 25,
    parameter int slow_clk_hz = 1,
    parameter int tm_clk_div  = 8
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [3:0]         key,
    input  logic [2:0]         sw,
    output logic [3:0]         led,
    output logic               sio_clk,
    output logic               sio_stb,
    output logic               sio_data_out,
    output logic               sio_data_oe,
    input  logic               sio_data_in,
    output logic               vga_hs,
    output logic               vga_vs,
    output logic [w_color-1:0] vga_r,
    output logic [w_color-1:0] vga_g,
    output logic [w_color-1:0] vga_b
);

    localparam int w_key_top = tm_keys + $bits(key);
    localparam int w_led_top = tm_leds + $bits(led);

    logic                 slow_tick;
    logic [w_key_top-1:0] key_top;
    logic [w_led_top-1:0] led_top;

    tm1638_if tm_bus ();
    vga_if    vga_bus ();

    // ----------------------------------------
    // TM1638 bits sit above the regular bits

    assign key_top = {tm_bus.keys, key};
    assign led     = led_top[$bits(led)-1:0];  // Upper part reaches the TM1638 through tm_bus

    assign vga_hs = vga_bus.hsync;
    assign vga_vs = vga_bus.vsync;

    // ----------------------------------------

    slow_tick_gen #(
        .clk_mhz     (clk_mhz),
        .slow_clk_hz (slow_clk_hz)
    ) i_slow_tick_gen (
        .clk       (clk),
        .reset     (reset),
        .slow_tick (slow_tick)
    );

    vga_timing #(
        .clk_mhz   (clk_mhz),
        .pixel_mhz (pixel_mhz)
    ) i_vga_timing (
        .clk   (clk),
        .reset (reset),
        .vga   (vga_bus)
    );

    tm1638_board_controller #(
        .clk_mhz    (clk_mhz),
        .tm_clk_div (tm_clk_div)
    ) i_tm1638 (
        .clk          (clk),
        .reset        (reset),
        .tm           (tm_bus),
        .sio_clk      (sio_clk),
        .sio_stb      (sio_stb),
        .sio_data_out (sio_data_out),
        .sio_data_oe  (sio_data_oe),
        .sio_data_in  (sio_data_in)
    );

    lab_top #(
        .w_key (w_key_top),
        .w_sw  ($bits(sw)),
        .w_led (w_led_top)
    ) i_lab_top (
        .clk       (clk),
        .reset     (reset),
        .slow_tick (slow_tick),
        .key       (key_top),
        .sw        (sw),
        .led       (led_top),
        .tm        (tm_bus),
        .vga       (vga_bus),
        .red       (vga_r),
        .green     (vga_g),
        .blue      (vga_b)
    );

endmodule

//--- tests/tb_board_top.sv
module tb_board_top;

    localparam int clk_mhz     = 2;
    localparam int pixel_mhz   = 1;
    localparam int slow_clk_hz = 100000;
    localparam int tm_clk_div  = 2;
    localparam int period      = 8;

    localparam int ticks     = clk_mhz * 1_000_000 / slow_clk_hz;  // 20 cycles
    localparam int r_pix     = clk_mhz / pixel_mhz;
    localparam int frame_len = 525 * 800 * r_pix;
    localparam int watchdog  = 2 * frame_len + 60000;

    logic       clk;
    logic       reset;
    logic [3:0] key;
    logic [2:0] sw;
    logic       sio_data_in = 1'b1;
    logic [3:0] led;
    logic       sio_clk;
    logic       sio_stb;
    logic       sio_data_out;
    logic       sio_data_oe;
    logic       vga_hs;
    logic       vga_vs;
    logic [3:0] vga_r;
    logic [3:0] vga_g;
    logic [3:0] vga_b;

    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    logic [31:0] lfsr = 32'hda3602ab;

    board_top #(
        .clk_mhz     (clk_mhz),
        .pixel_mhz   (pixel_mhz),
        .slow_clk_hz (slow_clk_hz),
        .tm_clk_div  (tm_clk_div)
    ) board_top_i (
        .clk          (clk),
        .reset        (reset),
        .key          (key),
        .sw           (sw),
        .led          (led),
        .sio_clk      (sio_clk),
        .sio_stb      (sio_stb),
        .sio_data_out (sio_data_out),
        .sio_data_oe  (sio_data_oe),
        .sio_data_in  (sio_data_in),
        .vga_hs       (vga_hs),
        .vga_vs       (vga_vs),
        .vga_r        (vga_r),
        .vga_g        (vga_g),
        .vga_b        (vga_b)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog * period);
        $display("Watchdog expired before the tests completed");
        $display("TESTBENCH FAILED");
        $finish;
    end

    // One step per bit taken with taps 32, 22, 2 and 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [7:0] glyph(input logic [3:0] n);
        logic [7:0] segs [16] = '{8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07,
                                  8'h7F, 8'h6F, 8'h77, 8'h7C, 8'h39, 8'h5E, 8'h79, 8'h71};
        return segs[n];
    endfunction

    // ----------------------------------------
    // Counter and raster models

    int          tick_cnt;
    logic [31:0] m_count;
    int          m_div;
    int          m_h;
    int          m_v;
    logic [9:0]  m_x;
    logic [9:0]  m_y;
    logic        m_on;
    logic [3:0]  exp_r;
    logic [3:0]  exp_g;
    logic [3:0]  exp_b;

    always @(posedge clk) begin
        if (reset) begin
            tick_cnt <= ticks - 1;
        end else begin
            tick_cnt <= (tick_cnt == 0) ? ticks - 1 : tick_cnt - 1;
        end
        if (reset || key[0]) begin
            m_count <= '0;
        end else if (tick_cnt == 0 && sw[0]) begin
            m_count <= m_count + 1;  // Strobe seen with the switch on
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            m_div <= 0;
            m_h   <= 0;
            m_v   <= 0;
            m_on  <= 1'b0;
            exp_r <= '0;
            exp_g <= '0;
            exp_b <= '0;
        end else begin
            m_div <= (m_div == r_pix - 1) ? 0 : m_div + 1;
            if (m_div == r_pix - 1) begin
                m_h <= (m_h == 799) ? 0 : m_h + 1;
                if (m_h == 799) begin
                    m_v <= (m_v == 524) ? 0 : m_v + 1;
                end
            end
            m_on  <= (m_h < 640) && (m_v < 480);
            exp_r <= m_on ? m_x[7:4] : 4'h0;
            exp_g <= m_on ? m_y[7:4] : 4'h0;
            exp_b <= m_on ? m_count[3:0] : 4'h0;
        end
        m_x <= 10'(m_h);
        m_y <= 10'(m_v);
    end

    // ----------------------------------------
    // TM1638 device model

    logic       prev_clk;
    logic       prev_stb;
    int         bit_cnt;
    int         frame_no;
    int         addr_frames;
    int         read_frames;
    logic [7:0] cur;
    logic [7:0] fbytes [$];
    logic [7:0] data_bytes [16];
    logic [7:0] key_vec;
    logic [7:0] keys_seen;

    function automatic logic in_read_phase();
        return fbytes.size() > 0 && fbytes[0] == 8'h42;
    endfunction

    function automatic logic answer_bit(input int b, input int j);
        if (j == 0) return key_vec[2 * b];
        if (j == 4) return key_vec[2 * b + 1];
        return 1'b0;
    endfunction

    task automatic end_frame();
        int         exp_len;
        logic [7:0] exp_cmd;
        case (frame_no % 4)
            0: begin
                exp_len = 1;
                exp_cmd = 8'h40;
            end
            1: begin
                exp_len = 17;
                exp_cmd = 8'hC0;
            end
            2: begin
                exp_len = 1;
                exp_cmd = 8'h8F;
            end
            default: begin
                exp_len = 5;
                exp_cmd = 8'h42;
            end
        endcase
        checks += 3;
        assert (bit_cnt == 0) else begin
            $display("Frame %0d ended in the middle of a byte", frame_no);
            errors++;
        end
        assert (fbytes.size() == exp_len) else begin
            $display("Frame %0d has %0d bytes instead of %0d",
                     frame_no, fbytes.size(), exp_len);
            errors++;
        end
        assert (fbytes.size() > 0 && fbytes[0] === exp_cmd) else begin
            $display("ERR sio_data_out command expected %h got %h", exp_cmd,
                     fbytes.size() > 0 ? fbytes[0] : 8'hxx);
            errors++;
        end
        if (frame_no % 4 == 1 && fbytes.size() == 17) begin
            for (int i = 0; i < 16; i++) data_bytes[i] = fbytes[i + 1];
            addr_frames++;
        end
        if (frame_no % 4 == 3) begin
            keys_seen = key_vec;
            read_frames++;
        end
        frame_no++;
        fbytes.delete();
        bit_cnt = 0;
    endtask

    // Pins are sampled before the edge updates them
    always @(posedge clk) begin
        if (reset) begin
            prev_clk = 1'b1;
            prev_stb = 1'b1;
            bit_cnt  = 0;
            frame_no = 0;
            cur      = '0;
            fbytes.delete();
        end else begin
            if (!sio_stb && prev_clk && !sio_clk && in_read_phase()) begin
                sio_data_in <= #1 answer_bit(fbytes.size() - 1, bit_cnt);
            end
            if (!sio_stb && !prev_clk && sio_clk) begin
                checks++;
                assert (sio_data_oe === !in_read_phase()) else begin
                    $display("ERR sio_data_oe expected %h got %h", !in_read_phase(), sio_data_oe);
                    errors++;
                end
                cur[bit_cnt] = sio_data_out;  // LSB first
                bit_cnt++;
                if (bit_cnt == 8) begin
                    fbytes.push_back(in_read_phase() ? 8'h00 : cur);
                    bit_cnt = 0;
                end
            end
            if (sio_stb) begin
                checks++;
                assert (sio_data_oe === 1'b1) else begin
                    $display("sio_data_oe released between frames");
                    errors++;
                end
            end
            if (!prev_stb && sio_stb) end_frame();
            prev_clk = sio_clk;
            prev_stb = sio_stb;
        end
    end

    // ----------------------------------------
    // Test tasks

    task automatic drive_inputs(input logic [3:0] k, input logic [2:0] s);
        @(posedge clk);
        #1;
        key = k;
        sw  = s;
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic wait_read_then_addr();
        int n;
        n = read_frames;
        while (read_frames == n) @(negedge clk);
        n = addr_frames;
        while (addr_frames == n) @(negedge clk);
    endtask

    task automatic check_addr_frame();
        logic [7:0] exp_led;
        logic [7:0] exp_byte;
        exp_led = m_count[11:4] ^ keys_seen;
        for (int i = 0; i < 8; i++) begin
            exp_byte = glyph(m_count[4 * i +: 4]);
            checks += 2;
            assert (data_bytes[2 * i] === exp_byte) else begin
                $display("ERR tm digit %0d expected %h got %h", i, exp_byte, data_bytes[2 * i]);
                errors++;
            end
            exp_byte = {7'b0, exp_led[i]};
            assert (data_bytes[2 * i + 1] === exp_byte) else begin
                $display("ERR tm led %0d expected %h got %h", i, exp_byte, data_bytes[2 * i + 1]);
                errors++;
            end
        end
    endtask

    function automatic logic sync_level(input logic vert);
        return vert ? vga_vs : vga_hs;
    endfunction

    task automatic measure_low(input logic vert, output int low, output int total);
        while (sync_level(vert) !== 1'b1) @(negedge clk);
        while (sync_level(vert) !== 1'b0) @(negedge clk);
        low   = 0;
        total = 0;
        while (sync_level(vert) === 1'b0) begin
            @(negedge clk);
            low++;
        end
        total = low;
        while (sync_level(vert) === 1'b1) begin
            @(negedge clk);
            total++;
        end
    endtask

    // ----------------------------------------
    // Main sequence

    initial begin
        int         e0;
        int         f0;
        int         low;
        int         total;
        logic [3:0] k;
        logic [3:0] exp_led;

        reset   = 1'b1;
        key     = '0;
        sw      = '0;
        key_vec = 8'(rand_bits(8));
        keys_seen   = '0;
        addr_frames = 0;
        read_frames = 0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        e0 = errors;
        for (int p = 0; p < 40; p++) begin
            k = 4'(rand_bits(4));
            if (rand_bits(3) != 0) k[0] = 1'b0;  // Clear only now and then
            drive_inputs(k, 3'(rand_bits(3)));
            repeat (ticks) begin
                @(negedge clk);
                exp_led = m_count[3:0] ^ key;
                checks++;
                assert (led === exp_led) else begin
                    $display("ERR led expected %h got %h", exp_led, led);
                    errors++;
                end
            end
        end
        finish_test("counter and leds", e0);

        e0 = errors;
        f0 = frame_no;
        while (frame_no < f0 + 8) @(negedge clk);
        finish_test("tm1638 protocol", e0);

        e0 = errors;
        drive_inputs(4'b0000, 3'b000);
        wait_read_then_addr();
        check_addr_frame();
        finish_test("hex digits", e0);

        e0 = errors;
        for (int r = 0; r < 2; r++) begin
            key_vec = 8'(rand_bits(8));
            wait_read_then_addr();
            check_addr_frame();
        end
        finish_test("key read-back", e0);

        e0 = errors;
        drive_inputs(4'b0000, 3'b001);
        while (m_v != 62) @(negedge clk);  // Lines 62 to 65 span two green values
        repeat (4 * 800 * r_pix) begin
            @(negedge clk);
            checks++;
            assert ({vga_r, vga_g, vga_b} === {exp_r, exp_g, exp_b}) else begin
                $display("ERR vga_rgb expected %h got %h", {exp_r, exp_g, exp_b},
                         {vga_r, vga_g, vga_b});
                errors++;
            end
        end
        finish_test("vga colors", e0);

        e0 = errors;
        measure_low(1'b0, low, total);
        checks += 2;
        assert (low == 96 * r_pix) else begin
            $display("ERR vga_hs low width expected %h got %h", 96 * r_pix, low);
            errors++;
        end
        assert (total == 800 * r_pix) else begin
            $display("ERR vga_hs period expected %h got %h", 800 * r_pix, total);
            errors++;
        end
        measure_low(1'b1, low, total);
        checks++;
        assert (low == 2 * 800 * r_pix) else begin
            $display("ERR vga_vs low width expected %h got %h", 2 * 800 * r_pix, low);
            errors++;
        end
        finish_test("vga sync", e0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
rtl/board_pkg.sv
rtl/tm1638_if.sv
rtl/vga_if.sv
rtl/slow_tick_gen.sv
rtl/vga_timing.sv
rtl/tm1638_board_controller.sv
rtl/lab_top.sv
rtl/board_top.sv
tests/tb_board_top.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= tb_board_top
RTL_TOP   ?= board_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary -j $(JOBS) $(VFLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
